// File: stq_cfg.svh
/*
 * configuration macros for the store unit
 * - data and address width
 * - rob tag width
 * - store queue depth and pointer width
 */
`ifndef STQ_CFG_SVH
`define STQ_CFG_SVH

// data and address width, every store writes one full word
`define STQ_XLEN 32

// rob tags wrap around, so age is judged by the sign of a tag difference
`define STQ_ROB_TAG_WIDTH 5

// queue depth must stay a power of two for the pointer arithmetic and rotation
`define STQ_SIZE 8

// head and tail carry one wrap bit above the entry index
`define STQ_TAG_WIDTH 4

`endif

// File: stq_pkg.sv
/*
 * shared types for the store unit
 * - vector typedefs for words, tags, indices and masks
 * - request structs for allocation, agu, cdb and memory
 * - state enum of the wishbone master
 */
`include "stq_cfg.svh"

package stq_pkg;

	typedef logic [`STQ_XLEN-1:0] xlen_t;
	typedef logic [`STQ_ROB_TAG_WIDTH-1:0] rob_tag_t;
	typedef logic [`STQ_TAG_WIDTH-1:0] stq_tag_t;
	typedef logic [$clog2(`STQ_SIZE)-1:0] stq_index_t;
	typedef logic [`STQ_SIZE-1:0] stq_mask_t;

	// a store entering the queue in program order
	// producer_tag only means something while data_valid is low
	typedef struct packed {
		rob_tag_t rob_tag;
		xlen_t data;
		logic data_valid;
		rob_tag_t producer_tag;
	} stq_alloc_t;

	// resolved address from the address generation unit
	typedef struct packed {
		rob_tag_t rob_tag;
		xlen_t address;
	} agu_result_t;

	// one broadcast on the common data bus
	typedef struct packed {
		rob_tag_t tag;
		xlen_t data;
	} cdb_result_t;

	// a committed store handed to the memory side
	typedef struct packed {
		stq_index_t index;
		rob_tag_t rob_tag;
		xlen_t address;
		xlen_t data;
	} store_req_t;

	typedef enum logic {
		wb_idle,
		wb_busy
	} wb_state_t;

endpackage

// File: store_queue.sv
/*
 * circular store queue
 * - allocation at the tail in program order
 * - address capture from the agu and data capture from the cdb
 * - commit, execute and success tracking per entry
 * - flush of young entries and retirement at the head
 * - head-rotated status masks for the issue selector
 */
`timescale 1ns/1ps
`include "stq_cfg.svh"

module store_queue (
	input logic clk,
	input logic reset,

	input logic alloc_valid,
	input stq_pkg::stq_alloc_t alloc,

	input logic agu_valid,
	input stq_pkg::agu_result_t agu,

	input logic cdb_valid,
	input stq_pkg::cdb_result_t cdb,

	input logic commit_valid,
	input stq_pkg::rob_tag_t commit_tag,

	input logic flush,
	input stq_pkg::rob_tag_t flush_tag,
	input stq_pkg::stq_tag_t new_tail,

	input logic fire,
	input stq_pkg::stq_index_t fire_index,

	input logic succeeded,
	input stq_pkg::rob_tag_t succeeded_tag,

	output stq_pkg::xlen_t [`STQ_SIZE-1:0] entry_address,
	output stq_pkg::xlen_t [`STQ_SIZE-1:0] entry_data,
	output stq_pkg::rob_tag_t [`STQ_SIZE-1:0] entry_rob_tag,

	output stq_pkg::stq_mask_t rot_valid,
	output stq_pkg::stq_mask_t rot_address_valid,
	output stq_pkg::stq_mask_t rot_data_valid,
	output stq_pkg::stq_mask_t rot_committed,
	output stq_pkg::stq_mask_t rot_executed,

	output stq_pkg::stq_tag_t head,
	output stq_pkg::stq_tag_t tail,
	output logic full
);

	// one queue slot, any new field has to be cleared in clear_entry as well
	typedef struct packed {
		logic valid;
		stq_pkg::xlen_t address;
		logic address_valid;
		stq_pkg::xlen_t data;
		logic data_valid;
		stq_pkg::rob_tag_t producer_tag;
		logic committed;
		logic executed;
		logic succeeded;
		stq_pkg::rob_tag_t rob_tag;
	} stq_entry_t;

	stq_entry_t [`STQ_SIZE-1:0] entries;
	stq_pkg::stq_index_t head_index;
	stq_pkg::stq_index_t tail_index;
	stq_pkg::stq_mask_t valid_mask;
	stq_pkg::stq_mask_t address_valid_mask;
	stq_pkg::stq_mask_t data_valid_mask;
	stq_pkg::stq_mask_t committed_mask;
	stq_pkg::stq_mask_t executed_mask;

	// the wrap bit is dropped to address the storage
	assign head_index = stq_pkg::stq_index_t'(head);
	assign tail_index = stq_pkg::stq_index_t'(tail);

	function automatic stq_entry_t clear_entry();
		stq_entry_t e;
		e.valid = 1'b0;
		e.address = '0;
		e.address_valid = 1'b0;
		e.data = '0;
		e.data_valid = 1'b0;
		e.producer_tag = '0;
		e.committed = 1'b0;
		e.executed = 1'b0;
		e.succeeded = 1'b0;
		e.rob_tag = '0;
		return e;
	endfunction

	// true when tag is the same age as base_tag or younger
	// the sign of the wrapped difference decides, tags are never a half range apart
	function automatic logic same_or_younger(stq_pkg::rob_tag_t tag,
			stq_pkg::rob_tag_t base_tag);
		stq_pkg::rob_tag_t diff;
		diff = tag - base_tag;
		return !diff[`STQ_ROB_TAG_WIDTH-1];
	endfunction

	// rotate a mask right so that the head entry lands in bit zero
	function automatic stq_pkg::stq_mask_t rotate(stq_pkg::stq_mask_t mask,
			stq_pkg::stq_index_t shift);
		return (mask >> shift) | (mask << (`STQ_SIZE - shift));
	endfunction

	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			for (int i = 0; i < `STQ_SIZE; i++) begin
				entries[i] <= clear_entry();
			end
		end else begin
			// the caller hands back the tail pointer, allocation is dropped on a flush
			if (flush) begin
				tail <= new_tail;
			end else if (alloc_valid) begin
				tail <= tail + 1'b1;
			end

			// only the head can have succeeded since one store is in flight at a time
			if (entries[head_index].valid && entries[head_index].succeeded) begin
				head <= head + 1'b1;
			end

			for (int i = 0; i < `STQ_SIZE; i++) begin
				if (flush && entries[i].valid
						&& same_or_younger(entries[i].rob_tag, flush_tag)) begin
					entries[i] <= clear_entry();
				end else begin
					// new store lands in the slot under the tail pointer
					if (alloc_valid && !flush && stq_pkg::stq_index_t'(i) == tail_index) begin
						entries[i].valid <= 1'b1;
						entries[i].rob_tag <= alloc.rob_tag;
						entries[i].data <= alloc.data;
						entries[i].data_valid <= alloc.data_valid;
						entries[i].producer_tag <= alloc.producer_tag;
					end

					// a fired store is not picked again while its write is on the bus
					if (entries[i].valid && fire && stq_pkg::stq_index_t'(i) == fire_index) begin
						entries[i].executed <= 1'b1;
					end

					if (entries[i].valid && agu_valid && agu.rob_tag == entries[i].rob_tag) begin
						entries[i].address <= agu.address;
						entries[i].address_valid <= 1'b1;
					end

					// producer_tag is stale once data is valid, so a matching cdb tag
					// must not overwrite the data after that
					if (entries[i].valid && !entries[i].data_valid && cdb_valid
							&& cdb.tag == entries[i].producer_tag) begin
						entries[i].data <= cdb.data;
						entries[i].data_valid <= 1'b1;
					end

					if (entries[i].valid && commit_valid && commit_tag == entries[i].rob_tag) begin
						entries[i].committed <= 1'b1;
					end

					if (entries[i].valid && succeeded
							&& succeeded_tag == entries[i].rob_tag) begin
						entries[i].succeeded <= 1'b1;
					end

					// retire the head one cycle after it is marked succeeded
					if (entries[i].valid && entries[i].succeeded
							&& stq_pkg::stq_index_t'(i) == head_index) begin
						entries[i] <= clear_entry();
					end
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `STQ_SIZE; i++) begin
			entry_address[i] = entries[i].address;
			entry_data[i] = entries[i].data;
			entry_rob_tag[i] = entries[i].rob_tag;
			valid_mask[i] = entries[i].valid;
			address_valid_mask[i] = entries[i].address_valid;
			data_valid_mask[i] = entries[i].data_valid;
			committed_mask[i] = entries[i].committed;
			executed_mask[i] = entries[i].executed;
		end
	end

	assign rot_valid = rotate(valid_mask, head_index);
	assign rot_address_valid = rotate(address_valid_mask, head_index);
	assign rot_data_valid = rotate(data_valid_mask, head_index);
	assign rot_committed = rotate(committed_mask, head_index);
	assign rot_executed = rotate(executed_mask, head_index);

	// tail points at the next free slot, so a valid entry there means no room
	assign full = entries[tail_index].valid;

endmodule

// File: store_issue_select.sv
/*
 * issue selector for committed stores
 * - ready-to-write mask from the head-rotated status masks
 * - priority encoder for the oldest ready store
 * - mapping back to a physical index and request build
 */
`timescale 1ns/1ps
`include "stq_cfg.svh"

module store_issue_select (
	input stq_pkg::stq_mask_t rot_valid,
	input stq_pkg::stq_mask_t rot_address_valid,
	input stq_pkg::stq_mask_t rot_data_valid,
	input stq_pkg::stq_mask_t rot_committed,
	input stq_pkg::stq_mask_t rot_executed,
	input stq_pkg::stq_tag_t head,

	input stq_pkg::xlen_t [`STQ_SIZE-1:0] entry_address,
	input stq_pkg::xlen_t [`STQ_SIZE-1:0] entry_data,
	input stq_pkg::rob_tag_t [`STQ_SIZE-1:0] entry_rob_tag,

	input logic ready,

	output logic fire,
	output stq_pkg::store_req_t req
);

	stq_pkg::stq_mask_t write_ready;
	stq_pkg::stq_index_t rot_pos;
	stq_pkg::stq_index_t phys_index;
	logic found;

	// a store may go to memory once it is complete, committed and not yet sent
	assign write_ready = rot_valid & rot_address_valid & rot_data_valid
			& rot_committed & ~rot_executed;

	// bit zero is the head, so the lowest set bit is the oldest candidate
	// scanning down from the top lets the lowest hit win
	always_comb begin
		found = 1'b0;
		rot_pos = '0;
		for (int i = `STQ_SIZE - 1; i >= 0; i--) begin
			if (write_ready[i]) begin
				found = 1'b1;
				rot_pos = stq_pkg::stq_index_t'(i);
			end
		end
	end

	// undo the rotation, the sum wraps at the queue size
	assign phys_index = rot_pos + stq_pkg::stq_index_t'(head);

	// nothing leaves while the master still has a write open
	assign fire = found && ready;

	assign req.index = phys_index;
	assign req.rob_tag = entry_rob_tag[phys_index];
	assign req.address = entry_address[phys_index];
	assign req.data = entry_data[phys_index];

endmodule

// File: store_wb_master.sv
/*
 * wishbone classic write master
 * - two-state FSM, one store in flight
 * - request latch on fire
 * - success pulse with the rob tag after ack
 */
`timescale 1ns/1ps
`include "stq_cfg.svh"

module store_wb_master (
	input logic clk,
	input logic reset,

	input logic fire,
	input stq_pkg::store_req_t req,
	output logic ready,

	output logic cyc,
	output logic stb,
	output logic we,
	output stq_pkg::xlen_t adr,
	output stq_pkg::xlen_t dat_w,
	output logic [3:0] sel,
	input logic ack,

	output logic succeeded,
	output stq_pkg::rob_tag_t succeeded_tag
);

	stq_pkg::wb_state_t state;
	stq_pkg::xlen_t adr_q;
	stq_pkg::xlen_t dat_q;
	stq_pkg::rob_tag_t tag_q;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= stq_pkg::wb_idle;
			succeeded <= 1'b0;
		end else begin
			// the success pulse lasts a single cycle
			succeeded <= 1'b0;
			case (state)
				stq_pkg::wb_idle: begin
					if (fire) begin
						state <= stq_pkg::wb_busy;
					end
				end
				stq_pkg::wb_busy: begin
					// cycle closes on the edge that samples ack
					if (ack) begin
						state <= stq_pkg::wb_idle;
						succeeded <= 1'b1;
					end
				end
				default: begin
					state <= stq_pkg::wb_idle;
				end
			endcase
		end
	end

	// request fields are held for the whole bus cycle
	always_ff @(posedge clk) begin
		if (state == stq_pkg::wb_idle && fire) begin
			adr_q <= req.address;
			dat_q <= req.data;
			tag_q <= req.rob_tag;
		end
	end

	assign ready = (state == stq_pkg::wb_idle);

	// cyc and stb rise and fall together, every cycle is a write
	assign cyc = (state == stq_pkg::wb_busy);
	assign stb = (state == stq_pkg::wb_busy);
	assign we = (state == stq_pkg::wb_busy);
	assign adr = adr_q;
	assign dat_w = dat_q;

	// full word stores only
	assign sel = 4'hf;

	// tag_q stays put until the next fire, which cannot come before this pulse
	assign succeeded_tag = tag_q;

endmodule

// File: store_unit.sv
/*
 * store unit top level
 * - store queue, issue selector and wishbone master
 * - core-side event ports and wishbone classic master port
 */
`timescale 1ns/1ps
`include "stq_cfg.svh"

module store_unit (
	input logic clk,
	input logic reset,

	input logic alloc_valid,
	input stq_pkg::stq_alloc_t alloc,
	input logic agu_valid,
	input stq_pkg::agu_result_t agu,
	input logic cdb_valid,
	input stq_pkg::cdb_result_t cdb,
	input logic commit_valid,
	input stq_pkg::rob_tag_t commit_tag,
	input logic flush,
	input stq_pkg::rob_tag_t flush_tag,
	input stq_pkg::stq_tag_t new_tail,

	output logic cyc,
	output logic stb,
	output logic we,
	output stq_pkg::xlen_t adr,
	output stq_pkg::xlen_t dat_w,
	output logic [3:0] sel,
	input logic ack,

	output logic full,
	output stq_pkg::stq_tag_t head,
	output stq_pkg::stq_tag_t tail
);

	stq_pkg::xlen_t [`STQ_SIZE-1:0] entry_address;
	stq_pkg::xlen_t [`STQ_SIZE-1:0] entry_data;
	stq_pkg::rob_tag_t [`STQ_SIZE-1:0] entry_rob_tag;
	stq_pkg::stq_mask_t rot_valid;
	stq_pkg::stq_mask_t rot_address_valid;
	stq_pkg::stq_mask_t rot_data_valid;
	stq_pkg::stq_mask_t rot_committed;
	stq_pkg::stq_mask_t rot_executed;
	logic fire;
	stq_pkg::store_req_t req;
	logic ready;
	logic succeeded;
	stq_pkg::rob_tag_t succeeded_tag;

	store_queue u_queue (
		.clk(clk), .reset(reset),
		.alloc_valid(alloc_valid), .alloc(alloc),
		.agu_valid(agu_valid), .agu(agu),
		.cdb_valid(cdb_valid), .cdb(cdb),
		.commit_valid(commit_valid), .commit_tag(commit_tag),
		.flush(flush), .flush_tag(flush_tag), .new_tail(new_tail),
		.fire(fire), .fire_index(req.index),
		.succeeded(succeeded), .succeeded_tag(succeeded_tag),
		.entry_address(entry_address), .entry_data(entry_data),
		.entry_rob_tag(entry_rob_tag),
		.rot_valid(rot_valid), .rot_address_valid(rot_address_valid),
		.rot_data_valid(rot_data_valid), .rot_committed(rot_committed),
		.rot_executed(rot_executed),
		.head(head), .tail(tail), .full(full)
	);

	// selection is combinational, the queue marks the entry executed on the fire edge
	store_issue_select u_select (
		.rot_valid(rot_valid), .rot_address_valid(rot_address_valid),
		.rot_data_valid(rot_data_valid), .rot_committed(rot_committed),
		.rot_executed(rot_executed), .head(head),
		.entry_address(entry_address), .entry_data(entry_data),
		.entry_rob_tag(entry_rob_tag),
		.ready(ready), .fire(fire), .req(req)
	);

	store_wb_master u_master (
		.clk(clk), .reset(reset),
		.fire(fire), .req(req), .ready(ready),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel), .ack(ack),
		.succeeded(succeeded), .succeeded_tag(succeeded_tag)
	);

endmodule

// File: store_unit_tb.sv
/*
 * testbench for the store unit
 * - clock, reset and a wishbone memory model with a random ack delay
 * - write and success tag logs, compare tasks typed to the DUT's types
 * - six directed tests and a cycle timeout
 */
`timescale 1ns/1ps
`include "stq_cfg.svh"

module store_unit_tb;

	localparam int timeout_cycles = 2000;

	logic clk = 1'b0;
	logic reset;
	logic alloc_valid;
	stq_pkg::stq_alloc_t alloc;
	logic agu_valid;
	stq_pkg::agu_result_t agu;
	logic cdb_valid;
	stq_pkg::cdb_result_t cdb;
	logic commit_valid;
	stq_pkg::rob_tag_t commit_tag;
	logic flush;
	stq_pkg::rob_tag_t flush_tag;
	stq_pkg::stq_tag_t new_tail;
	logic cyc;
	logic stb;
	logic we;
	stq_pkg::xlen_t adr;
	stq_pkg::xlen_t dat_w;
	logic [3:0] sel;
	logic ack = 1'b0;
	logic full;
	stq_pkg::stq_tag_t head;
	stq_pkg::stq_tag_t tail;

	// what the memory saw, and what the tests expect it to see
	stq_pkg::xlen_t write_adr[$];
	stq_pkg::xlen_t write_dat[$];
	stq_pkg::rob_tag_t done_tag[$];
	stq_pkg::xlen_t exp_adr[$];
	stq_pkg::xlen_t exp_dat[$];
	stq_pkg::rob_tag_t exp_tag[$];

	// the tail pointer counted from the allocations and flushes sent so far
	stq_pkg::stq_tag_t alloc_tail = '0;

	int error_count = 0;
	int test_count = 0;
	int failed_count = 0;
	int errors_at_start = 0;
	int cycle_count = 0;
	int write_count = 0;
	int delay_left = 0;
	logic in_cycle = 1'b0;
	int unsigned seed_value;
	int unsigned ack_delay[64];
	string test_name;

	always #2 clk = ~clk;

	store_unit DUT (
		.clk(clk), .reset(reset),
		.alloc_valid(alloc_valid), .alloc(alloc), .agu_valid(agu_valid), .agu(agu),
		.cdb_valid(cdb_valid), .cdb(cdb), .commit_valid(commit_valid), .commit_tag(commit_tag),
		.flush(flush), .flush_tag(flush_tag), .new_tail(new_tail),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel), .ack(ack),
		.full(full), .head(head), .tail(tail)
	);

	// memory model that raises ack 0 to 3 cycles after stb is first seen
	always @(posedge clk) begin
		if (!reset) begin
			ack <= 1'b0;
			in_cycle <= 1'b0;
			delay_left <= 0;
		end else if (ack) begin
			// the master samples ack on this edge and closes the cycle
			ack <= 1'b0;
			in_cycle <= 1'b0;
			write_adr.push_back(adr);
			write_dat.push_back(dat_w);
			check_bit("we", we, 1'b1);
			check_sel("sel", sel, 4'hf);
			write_count++;
		end else if (cyc && stb) begin
			if (!in_cycle) begin
				in_cycle <= 1'b1;
				if (ack_delay[write_count % 64] == 0) begin
					ack <= 1'b1;
				end else begin
					delay_left <= ack_delay[write_count % 64] - 1;
				end
			end else if (delay_left == 0) begin
				ack <= 1'b1;
			end else begin
				delay_left <= delay_left - 1;
			end
		end
	end

	// the success pulse reports which store memory took
	always @(posedge clk) begin
		if (reset && DUT.u_master.succeeded) begin
			done_tag.push_back(DUT.u_master.succeeded_tag);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("run stopped after %0d cycles, a test never finished", cycle_count);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_xlen(input string name, input stq_pkg::xlen_t got,
			input stq_pkg::xlen_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_rob_tag(input string name, input stq_pkg::rob_tag_t got,
			input stq_pkg::rob_tag_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_stq_tag(input string name, input stq_pkg::stq_tag_t got,
			input stq_pkg::stq_tag_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_sel(input string name, input logic [3:0] got,
			input logic [3:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	// address and data of a store follow from its rob tag
	function automatic stq_pkg::xlen_t addr_for(input stq_pkg::rob_tag_t tag);
		return 32'h0000_1000 + {tag, 2'b00};
	endfunction

	function automatic stq_pkg::xlen_t data_for(input stq_pkg::rob_tag_t tag);
		return 32'hc0de_0000 | tag;
	endfunction

	task automatic send_alloc(input stq_pkg::rob_tag_t tag, input stq_pkg::xlen_t data,
			input logic data_valid, input stq_pkg::rob_tag_t producer);
		stq_pkg::stq_alloc_t a;
		a.rob_tag = tag;
		a.data = data;
		a.data_valid = data_valid;
		a.producer_tag = producer;
		@(posedge clk);
		alloc_valid <= 1'b1;
		alloc <= a;
		alloc_tail = alloc_tail + 1'b1;
		@(posedge clk);
		alloc_valid <= 1'b0;
	endtask

	task automatic send_agu(input stq_pkg::rob_tag_t tag, input stq_pkg::xlen_t address);
		stq_pkg::agu_result_t r;
		r.rob_tag = tag;
		r.address = address;
		@(posedge clk);
		agu_valid <= 1'b1;
		agu <= r;
		@(posedge clk);
		agu_valid <= 1'b0;
	endtask

	task automatic send_cdb(input stq_pkg::rob_tag_t tag, input stq_pkg::xlen_t data);
		stq_pkg::cdb_result_t r;
		r.tag = tag;
		r.data = data;
		@(posedge clk);
		cdb_valid <= 1'b1;
		cdb <= r;
		@(posedge clk);
		cdb_valid <= 1'b0;
	endtask

	task automatic send_commit(input stq_pkg::rob_tag_t tag);
		@(posedge clk);
		commit_valid <= 1'b1;
		commit_tag <= tag;
		@(posedge clk);
		commit_valid <= 1'b0;
	endtask

	task automatic send_flush(input stq_pkg::rob_tag_t tag, input stq_pkg::stq_tag_t tail_value);
		@(posedge clk);
		flush <= 1'b1;
		flush_tag <= tag;
		new_tail <= tail_value;
		alloc_tail = tail_value;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	task automatic expect_write(input stq_pkg::rob_tag_t tag, input stq_pkg::xlen_t address,
			input stq_pkg::xlen_t data);
		exp_tag.push_back(tag);
		exp_adr.push_back(address);
		exp_dat.push_back(data);
	endtask

	// the queue is empty once head has caught up with tail and the bus is idle
	task automatic wait_drained();
		@(negedge clk);
		while (head !== tail || cyc === 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic watch_bus_quiet(input int cycles);
		logic seen;
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			seen = seen | cyc;
		end
		check_bit("cyc", seen, 1'b0);
	endtask

	task automatic compare_writes();
		if (write_adr.size() != exp_adr.size()) begin
			$display("expected %0d bus writes, memory saw %0d", exp_adr.size(), write_adr.size());
			error_count++;
		end
		for (int i = 0; i < exp_adr.size() && i < write_adr.size(); i++) begin
			check_xlen("adr", write_adr[i], exp_adr[i]);
			check_xlen("dat_w", write_dat[i], exp_dat[i]);
		end
		if (done_tag.size() != exp_tag.size()) begin
			$display("expected %0d success pulses, saw %0d", exp_tag.size(), done_tag.size());
			error_count++;
		end
		for (int i = 0; i < exp_tag.size() && i < done_tag.size(); i++) begin
			check_rob_tag("succeeded_tag", done_tag[i], exp_tag[i]);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
		write_adr.delete();
		write_dat.delete();
		done_tag.delete();
		exp_adr.delete();
		exp_dat.delete();
		exp_tag.delete();
	endtask

	task automatic finish_test();
		test_count++;
		if (error_count != errors_at_start) begin
			failed_count++;
			$display("test %0d %s: FAIL", test_count, test_name);
		end else begin
			$display("test %0d %s: pass", test_count, test_name);
		end
	endtask

	task automatic test_reset();
		start_test("reset values");
		@(negedge clk);
		check_stq_tag("head", head, '0);
		check_stq_tag("tail", tail, '0);
		check_bit("full", full, 1'b0);
		check_bit("cyc", cyc, 1'b0);
		check_bit("stb", stb, 1'b0);
		finish_test();
	endtask

	task automatic test_in_order_drain();
		stq_pkg::stq_tag_t t0;
		start_test("three stores drain in allocation order");
		@(negedge clk);
		t0 = alloc_tail;
		for (int i = 1; i <= 3; i++) begin
			send_alloc(i, data_for(i), 1'b1, '0);
			expect_write(i, addr_for(i), data_for(i));
		end
		// addresses resolve out of program order
		send_agu(3, addr_for(3));
		send_agu(1, addr_for(1));
		send_agu(2, addr_for(2));
		for (int i = 1; i <= 3; i++) begin
			send_commit(i);
		end
		wait_drained();
		compare_writes();
		check_stq_tag("head", head, t0 + 3);
		check_stq_tag("tail", tail, t0 + 3);
		finish_test();
	endtask

	task automatic test_cdb_wakeup();
		start_test("data arrives from the cdb");
		send_alloc(4, '0, 1'b0, 20);
		send_agu(4, addr_for(4));
		send_commit(4);
		watch_bus_quiet(12);
		// a broadcast for another producer leaves the store waiting
		send_cdb(21, 32'hbad0_0021);
		watch_bus_quiet(12);
		send_cdb(20, 32'h5eed_0020);
		expect_write(4, addr_for(4), 32'h5eed_0020);
		wait_drained();
		compare_writes();
		finish_test();
	endtask

	task automatic test_commit_gate();
		start_test("store waits for commit");
		send_alloc(5, data_for(5), 1'b1, '0);
		send_agu(5, addr_for(5));
		watch_bus_quiet(40);
		send_commit(5);
		expect_write(5, addr_for(5), data_for(5));
		wait_drained();
		compare_writes();
		finish_test();
	endtask

	task automatic test_flush();
		stq_pkg::stq_tag_t t0;
		stq_pkg::stq_tag_t kept_tail;
		start_test("flush drops the two youngest stores");
		@(negedge clk);
		t0 = alloc_tail;
		kept_tail = t0 + 2;
		for (int i = 6; i <= 9; i++) begin
			send_alloc(i, data_for(i), 1'b1, '0);
			send_agu(i, addr_for(i));
		end
		send_flush(8, kept_tail);
		@(negedge clk);
		check_stq_tag("tail", tail, kept_tail);
		// commits for the flushed tags find no entry
		for (int i = 6; i <= 9; i++) begin
			send_commit(i);
		end
		expect_write(6, addr_for(6), data_for(6));
		expect_write(7, addr_for(7), data_for(7));
		wait_drained();
		watch_bus_quiet(10);
		compare_writes();
		finish_test();
	endtask

	task automatic test_fill_and_drain();
		stq_pkg::stq_tag_t h0;
		start_test("full queue drains in order");
		@(negedge clk);
		h0 = head;
		for (int i = 0; i < `STQ_SIZE; i++) begin
			send_alloc(10 + i, data_for(10 + i), 1'b1, '0);
			@(negedge clk);
			check_bit("full", full, i == `STQ_SIZE - 1);
			expect_write(10 + i, addr_for(10 + i), data_for(10 + i));
		end
		for (int i = 0; i < `STQ_SIZE; i++) begin
			send_agu(10 + i, addr_for(10 + i));
		end
		for (int i = 0; i < `STQ_SIZE; i++) begin
			send_commit(10 + i);
		end
		// the first retirement frees the slot under the tail
		while (head === h0) begin
			@(negedge clk);
		end
		check_bit("full", full, 1'b0);
		wait_drained();
		compare_writes();
		finish_test();
	endtask

	initial begin
		seed_value = $urandom(32'hc039_ab87);
		for (int i = 0; i < 64; i++) begin
			ack_delay[i] = $urandom_range(3, 0);
		end
		reset = 1'b0;
		alloc_valid = 1'b0;
		alloc = '0;
		agu_valid = 1'b0;
		agu = '0;
		cdb_valid = 1'b0;
		cdb = '0;
		commit_valid = 1'b0;
		commit_tag = '0;
		flush = 1'b0;
		flush_tag = '0;
		new_tail = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b1;
		test_reset();
		test_in_order_drain();
		test_cdb_wakeup();
		test_commit_gate();
		test_flush();
		test_fill_and_drain();
		@(negedge clk);
		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_count, error_count);
		if (error_count == 0 && failed_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: store_unit.f
+incdir+.
stq_pkg.sv
store_queue.sv
store_issue_select.sv
store_wb_master.sv
store_unit.sv
store_unit_tb.sv

// File: Bender.yml
package:
  name: store_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - stq_pkg.sv
      - store_queue.sv
      - store_issue_select.sv
      - store_wb_master.sv
      - store_unit.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - store_unit_tb.sv
